//--- rtl/st_bus_pkg.sv
/* Stream widths shared by the bridges, the arbiter, the interfaces and the top level.
   Import it wherever a beat width or an empty-count width is needed */
`default_nettype none

package st_bus_pkg;

    localparam int data_bytes = 4; // Default bytes per stream beat
    localparam int id_width   = 4; // Default width of tid and channel

    // Number of bits needed to count the empty bytes of a beat
    function automatic int empty_width_of(input int bytes);
        int width;
        width = 1; // A single-byte beat still keeps a one-bit field
        if (bytes > 2) begin
            width = $clog2(bytes);
        end
        return width;
    endfunction

endpackage

`default_nettype wire

//--- rtl/st_arb_pkg.sv
/* Packet arbiter definitions: port count, grant index type and FSM encoding.
   Imported by the arbiter and by the top level that sizes it */
`default_nettype none

package st_arb_pkg;

    localparam int num_ports = 2; // Default number of requesting peers

    localparam int port_idx_width = (num_ports > 1) ? $clog2(num_ports) : 1;

    typedef logic [port_idx_width-1:0] port_idx_t; // Index of the granted port

    // Arbiter FSM states
    typedef enum logic [1:0] {
        arb_idle    = 2'd0, // No grant is held
        arb_granted = 2'd1, // Ack is high for exactly one port
        arb_release = 2'd2  // Ack has fallen, one cycle before a new grant
    } arb_state_t;

endpackage

`default_nettype wire

//--- rtl/axi4_stream_if.sv
/* AXI4-Stream bundle between the top-level ports and a bridge.
   The bridge takes the rx modport, the feeding side the tx modport */
`timescale 1ns/100ps
`default_nettype none

interface axi4_stream_if
    import st_bus_pkg::*;
#(
    parameter int DATA_BYTES = data_bytes,
    parameter int ID_WIDTH   = id_width
) ();

    logic                    tvalid; // Beat present
    logic                    tready; // Receiver can take the beat
    logic [8*DATA_BYTES-1:0] tdata;
    logic [DATA_BYTES-1:0]   tkeep;  // Byte belongs to the stream
    logic [DATA_BYTES-1:0]   tstrb;  // Byte carries data rather than position
    logic                    tlast;  // Last beat of a packet
    logic [ID_WIDTH-1:0]     tid;    // Stream identifier

    modport rx (
        input  tvalid, tdata, tkeep, tstrb, tlast, tid,
        output tready
    );

    modport tx (
        output tvalid, tdata, tkeep, tstrb, tlast, tid,
        input  tready
    );

endinterface

`default_nettype wire

//--- rtl/avalon_st_if.sv
/* Avalon-ST bundle with the bus request pair used by the packet arbiter.
   A bridge drives the source modport and the arbiter takes the sink modport */
`timescale 1ns/100ps
`default_nettype none

interface avalon_st_if
    import st_bus_pkg::*;
#(
    parameter int DATA_BYTES = data_bytes,
    parameter int ID_WIDTH   = id_width
) ();

    logic                                  valid;
    logic                                  ready;
    logic [8*DATA_BYTES-1:0]               data;
    logic [empty_width_of(DATA_BYTES)-1:0] empty;   // Unused bytes in the last beat
    logic [ID_WIDTH-1:0]                   channel;
    logic                                  startofpacket;
    logic                                  endofpacket;
    logic                                  req;     // Source asks for the shared bus
    logic                                  ack;     // Shared bus is owned by this source

    modport source (
        output valid, data, empty, channel, startofpacket, endofpacket, req,
        input  ready, ack
    );

    modport sink (
        input  valid, data, empty, channel, startofpacket, endofpacket, req,
        output ready, ack
    );

endinterface

`default_nettype wire

//--- rtl/axi4s_to_avalon_st.sv
/* One-stage AXI4-Stream to Avalon-ST bridge that also requests the shared output bus
   for each packet with a four-phase req/ack handshake */
`timescale 1ns/100ps
`default_nettype none

module axi4s_to_avalon_st
    import st_bus_pkg::*;
#(
    parameter int DATA_BYTES = data_bytes,
    parameter int ID_WIDTH   = id_width
) (
    input wire          aclk,
    input wire          areset_n,
    axi4_stream_if.rx   rx,
    avalon_st_if.source tx
);

    localparam int EMPTY_WIDTH = empty_width_of(DATA_BYTES);

    logic                    valid_q;   // Output register holds a beat
    logic [8*DATA_BYTES-1:0] data_q;
    logic [EMPTY_WIDTH-1:0]  empty_q;
    logic [ID_WIDTH-1:0]     channel_q;
    logic                    sop_q;
    logic                    eop_q;
    logic                    sop_armed; // Next accepted beat opens a packet
    logic                    req_q;
    logic                    accept;    // Input beat taken this cycle
    logic                    drain;     // Output beat leaves this cycle

    // Counts the bytes that are not both kept and strobed
    function automatic logic [EMPTY_WIDTH-1:0] bytes_not_set(
        input logic [DATA_BYTES-1:0] keep,
        input logic [DATA_BYTES-1:0] strb
    );
        int count;
        count = 0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (!(keep[i] && strb[i])) begin
                count++;
            end
        end
        return count[EMPTY_WIDTH-1:0];
    endfunction

    assign drain     = valid_q && tx.ready;
    assign rx.tready = !valid_q || tx.ready; // Register empty or emptying now
    assign accept    = rx.tvalid && rx.tready;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            valid_q <= 1'b0;
        end else if (rx.tready) begin
            valid_q <= rx.tvalid; // Refill or go empty once drained
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            sop_armed <= 1'b1; // First beat after reset starts a packet
        end else if (accept) begin
            sop_armed <= rx.tlast; // A closing beat rearms the tracker
        end
    end

    // Payload stage, qualified by valid_q
    always_ff @(posedge aclk) begin
        if (accept) begin
            data_q    <= rx.tdata;
            channel_q <= rx.tid;
            eop_q     <= rx.tlast;
            sop_q     <= sop_armed;
            empty_q   <= bytes_not_set(rx.tkeep, rx.tstrb);
        end
    end

    // Request opens on a held start beat and closes once the end beat has gone
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            req_q <= 1'b0;
        end else if (req_q) begin
            if (drain && eop_q) begin
                req_q <= 1'b0; // Packet finished on the shared bus
            end
        end else if (valid_q && sop_q && !tx.ack) begin
            req_q <= 1'b1; // Previous grant fully withdrawn
        end
    end

    assign tx.valid         = valid_q;
    assign tx.data          = data_q;
    assign tx.empty         = empty_q;
    assign tx.channel       = channel_q;
    assign tx.startofpacket = sop_q;
    assign tx.endofpacket   = eop_q;
    assign tx.req           = req_q;

endmodule

`default_nettype wire

//--- rtl/st_packet_arbiter.sv
/* Round-robin packet arbiter with four-phase req/ack per peer.
   The granted peer drives the shared output for one whole packet */
`timescale 1ns/100ps
`default_nettype none

module st_packet_arbiter
    import st_bus_pkg::*;
    import st_arb_pkg::*;
#(
    parameter int NUM_PORTS  = num_ports,
    parameter int DATA_BYTES = data_bytes,
    parameter int ID_WIDTH   = id_width
) (
    input wire          aclk,
    input wire          areset_n,
    avalon_st_if.sink   peers [NUM_PORTS],
    avalon_st_if.source out
);

    localparam int EMPTY_WIDTH = empty_width_of(DATA_BYTES);

    logic [NUM_PORTS-1:0]    peer_valid;
    logic [NUM_PORTS-1:0]    peer_req;
    logic [NUM_PORTS-1:0]    peer_sop;
    logic [NUM_PORTS-1:0]    peer_eop;
    logic [8*DATA_BYTES-1:0] peer_data    [NUM_PORTS];
    logic [EMPTY_WIDTH-1:0]  peer_empty   [NUM_PORTS];
    logic [ID_WIDTH-1:0]     peer_channel [NUM_PORTS];

    arb_state_t state;
    port_idx_t  grant;      // Current grant, and the round-robin pointer afterwards
    port_idx_t  next_grant;
    logic       next_found;
    logic       active;     // Granted peer still holds its request

    // Per-port views of the peer buses, indexed by the grant below
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_peer
        assign peer_valid[p]   = peers[p].valid;
        assign peer_req[p]     = peers[p].req;
        assign peer_sop[p]     = peers[p].startofpacket;
        assign peer_eop[p]     = peers[p].endofpacket;
        assign peer_data[p]    = peers[p].data;
        assign peer_empty[p]   = peers[p].empty;
        assign peer_channel[p] = peers[p].channel;
        assign peers[p].ack    = (state == arb_granted) && (grant == port_idx_t'(p));
        assign peers[p].ready  = active && (grant == port_idx_t'(p)) && out.ready;
    end

    // Search starts at the port after the last grant
    always_comb begin
        int idx;
        next_grant = grant;
        next_found = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(grant) + i) % NUM_PORTS;
            if (!next_found && peer_req[idx]) begin
                next_grant = port_idx_t'(idx);
                next_found = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= arb_idle;
            grant <= port_idx_t'(NUM_PORTS - 1); // Port 0 wins the first search
        end else begin
            case (state)
                arb_idle: begin
                    if (next_found) begin
                        grant <= next_grant;
                        state <= arb_granted;
                    end
                end
                arb_granted: begin
                    if (!peer_req[grant]) begin
                        state <= arb_release; // Ack falls with this move
                    end
                end
                arb_release: state <= arb_idle;
                default:     state <= arb_idle;
            endcase
        end
    end

    // Beats of the next packet wait while req is low and ack still high
    assign active = (state == arb_granted) && peer_req[grant];

    assign out.valid         = active && peer_valid[grant];
    assign out.data          = peer_data[grant];
    assign out.empty         = peer_empty[grant];
    assign out.channel       = peer_channel[grant];
    assign out.startofpacket = peer_sop[grant];
    assign out.endofpacket   = peer_eop[grant];

endmodule

`default_nettype wire

//--- rtl/st_merge_top.sv
/* Merges two AXI4-Stream sources onto one Avalon-ST output, a whole packet at a time.
   Plain ports outside, interfaces between the bridges and the arbiter inside */
`timescale 1ns/100ps
`default_nettype none

module st_merge_top
    import st_bus_pkg::*;
    import st_arb_pkg::*;
#(
    parameter int DATA_BYTES = data_bytes,
    parameter int ID_WIDTH   = id_width
) (
    input  wire                                   aclk,
    input  wire                                   areset_n,
    input  wire                                   s0_tvalid,
    input  wire  [8*DATA_BYTES-1:0]               s0_tdata,
    input  wire  [DATA_BYTES-1:0]                 s0_tkeep,
    input  wire  [DATA_BYTES-1:0]                 s0_tstrb,
    input  wire                                   s0_tlast,
    input  wire  [ID_WIDTH-1:0]                   s0_tid,
    output logic                                  s0_tready,
    input  wire                                   s1_tvalid,
    input  wire  [8*DATA_BYTES-1:0]               s1_tdata,
    input  wire  [DATA_BYTES-1:0]                 s1_tkeep,
    input  wire  [DATA_BYTES-1:0]                 s1_tstrb,
    input  wire                                   s1_tlast,
    input  wire  [ID_WIDTH-1:0]                   s1_tid,
    output logic                                  s1_tready,
    output logic                                  out_valid,
    output logic [8*DATA_BYTES-1:0]               out_data,
    output logic [empty_width_of(DATA_BYTES)-1:0] out_empty,
    output logic [ID_WIDTH-1:0]                   out_channel,
    output logic                                  out_startofpacket,
    output logic                                  out_endofpacket,
    input  wire                                   out_ready
);

    localparam int NUM_PORTS = num_ports; // One bridge per port

    axi4_stream_if #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) s0_axis ();
    axi4_stream_if #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) s1_axis ();
    avalon_st_if   #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) peer_st [NUM_PORTS] ();
    avalon_st_if   #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) out_st ();

    assign s0_axis.tvalid = s0_tvalid;
    assign s0_axis.tdata  = s0_tdata;
    assign s0_axis.tkeep  = s0_tkeep;
    assign s0_axis.tstrb  = s0_tstrb;
    assign s0_axis.tlast  = s0_tlast;
    assign s0_axis.tid    = s0_tid;
    assign s0_tready      = s0_axis.tready;

    assign s1_axis.tvalid = s1_tvalid;
    assign s1_axis.tdata  = s1_tdata;
    assign s1_axis.tkeep  = s1_tkeep;
    assign s1_axis.tstrb  = s1_tstrb;
    assign s1_axis.tlast  = s1_tlast;
    assign s1_axis.tid    = s1_tid;
    assign s1_tready      = s1_axis.tready;

    axi4s_to_avalon_st #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) bridge0_inst (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx       (s0_axis),
        .tx       (peer_st[0])
    );

    axi4s_to_avalon_st #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) bridge1_inst (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx       (s1_axis),
        .tx       (peer_st[1])
    );

    st_packet_arbiter #(
        .NUM_PORTS  (NUM_PORTS),
        .DATA_BYTES (DATA_BYTES),
        .ID_WIDTH   (ID_WIDTH)
    ) arbiter_inst (
        .aclk     (aclk),
        .areset_n (areset_n),
        .peers    (peer_st),
        .out      (out_st)
    );

    assign out_valid         = out_st.valid;
    assign out_data          = out_st.data;
    assign out_empty         = out_st.empty;
    assign out_channel       = out_st.channel;
    assign out_startofpacket = out_st.startofpacket;
    assign out_endofpacket   = out_st.endofpacket;
    assign out_st.ready      = out_ready;

endmodule

`default_nettype wire

//--- test/tb_st_merge_top.sv
/* Self-checking testbench for st_merge_top. Two random packet sources feed the DUT,
   scoreboards per source and assertions check the merged Avalon-ST output */
`timescale 1ns/100ps
`default_nettype none

module tb_st_merge_top
    import st_bus_pkg::*;
();

    localparam int DATA_BYTES   = data_bytes;
    localparam int ID_WIDTH     = id_width;
    localparam int EMPTY_W      = empty_width_of(data_bytes);
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 16;
    localparam int PACKETS      = 12; // Packets per source in each test
    localparam int NUM_TESTS    = 3;

    typedef struct packed {
        logic [8*DATA_BYTES-1:0] data;
        logic [ID_WIDTH-1:0]     channel;
        logic                    eop;
        logic [EMPTY_W-1:0]      empty;
    } beat_t;

    logic                    aclk;
    logic                    areset_n;
    logic [1:0]              tvalid;
    logic [1:0]              tlast;
    wire  [1:0]              tready;
    logic [8*DATA_BYTES-1:0] tdata [2];
    logic [DATA_BYTES-1:0]   tkeep [2];
    logic [DATA_BYTES-1:0]   tstrb [2];
    logic [ID_WIDTH-1:0]     tid [2];
    logic                    out_ready;
    logic                    out_valid;
    logic [8*DATA_BYTES-1:0] out_data;
    logic [EMPTY_W-1:0]      out_empty;
    logic [ID_WIDTH-1:0]     out_channel;
    logic                    out_sop;
    logic                    out_eop;
    logic [8*DATA_BYTES+EMPTY_W+ID_WIDTH+2:0] out_beat;
    logic [8*DATA_BYTES+EMPTY_W+ID_WIDTH+2:0] hold_beat; // Output seen on the stalled edge

    beat_t exp_q [2][$];   // Accepted beats not yet seen at the output
    int    pkt_len_q [2][$];
    int    errors = 0;
    int    checked = 0;
    int    tests_done = 0;
    int    total_beats = 0;
    int    ready_pct = 0;  // Chance in percent that out_ready is high
    int    pkt_port;       // Source of the packet now on the output
    int    last_port;
    int    port;
    bit    expect_sop;
    bit    fair_pending;   // Both sources had a packet waiting at the last end beat
    bit    hold_q;
    beat_t head;

    st_merge_top #(.DATA_BYTES(DATA_BYTES), .ID_WIDTH(ID_WIDTH)) st_merge_top_inst (
        .aclk (aclk), .areset_n (areset_n),
        .s0_tvalid (tvalid[0]), .s0_tdata (tdata[0]), .s0_tkeep (tkeep[0]),
        .s0_tstrb (tstrb[0]), .s0_tlast (tlast[0]), .s0_tid (tid[0]), .s0_tready (tready[0]),
        .s1_tvalid (tvalid[1]), .s1_tdata (tdata[1]), .s1_tkeep (tkeep[1]),
        .s1_tstrb (tstrb[1]), .s1_tlast (tlast[1]), .s1_tid (tid[1]), .s1_tready (tready[1]),
        .out_valid (out_valid), .out_data (out_data), .out_empty (out_empty),
        .out_channel (out_channel), .out_startofpacket (out_sop),
        .out_endofpacket (out_eop), .out_ready (out_ready)
    );

    assign out_beat = {out_valid, out_data, out_empty, out_channel, out_sop, out_eop};

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
        errors++;
    endtask

    // Expected Avalon-ST beat for the AXI4-Stream beat now offered by source p
    function automatic beat_t expected_beat(input int p);
        beat_t b;
        b.data    = tdata[p];
        b.channel = tid[p];
        b.eop     = tlast[p];
        b.empty   = EMPTY_W'($countones(~(tkeep[p] & tstrb[p]))); // Bytes not both kept and strobed
        return b;
    endfunction

    // Output stays quiet in reset and in the first cycle after it
    assert property (@(posedge aclk) !areset_n |-> !out_valid)
        else report_mismatch("out_valid", 1, 0);
    assert property (@(posedge aclk) $rose(areset_n) |-> !out_valid)
        else report_mismatch("out_valid", 1, 0);

    always @(posedge aclk) begin
        out_ready <= areset_n && ($urandom_range(99) < ready_pct);
    end

    always @(posedge aclk) begin
        if (!areset_n) begin
            expect_sop   = 1'b1; // First beat after reset opens a packet
            fair_pending = 1'b0;
            hold_q       = 1'b0;
            pkt_port     = -1;
        end else begin
            if (hold_q) begin
                assert (out_beat == hold_beat)
                    else report_mismatch("out_beat", out_beat, hold_beat);
            end
            if (out_valid && out_ready) begin
                checked++;
                port = (out_channel >= 8) ? 1 : 0; // Channel range names the source
                assert (exp_q[port].size() != 0) else begin
                    $display("Beat on channel %0d at %0t was never sent", out_channel, $time);
                    errors++;
                end
                if (exp_q[port].size() != 0) begin
                    head = exp_q[port].pop_front();
                    assert (out_data == head.data)
                        else report_mismatch("out_data", out_data, head.data);
                    assert (out_channel == head.channel)
                        else report_mismatch("out_channel", out_channel, head.channel);
                    assert (out_eop == head.eop)
                        else report_mismatch("out_endofpacket", out_eop, head.eop);
                    assert (out_empty == head.empty)
                        else report_mismatch("out_empty", out_empty, head.empty);
                end
                assert (out_sop == expect_sop)
                    else report_mismatch("out_startofpacket", out_sop, expect_sop);
                if (expect_sop) begin
                    assert (!fair_pending || port != last_port) else begin
                        $display("Source %0d granted twice in a row at %0t with both waiting",
                                 port, $time);
                        errors++;
                    end
                    pkt_port = port;
                end else begin
                    assert (port == pkt_port)
                        else report_mismatch("source of out_channel", port, pkt_port);
                end
                if (out_eop) begin
                    last_port    = port;
                    fair_pending = exp_q[0].size() != 0 && exp_q[1].size() != 0;
                end
                expect_sop = out_eop; // Beat after an end beat opens the next packet
            end
            for (int p = 0; p < 2; p++) begin
                if (tvalid[p] && tready[p]) exp_q[p].push_back(expected_beat(p));
            end
            hold_q    = out_valid && !out_ready;
            hold_beat = out_beat;
        end
    end

    task automatic send_packets(input int p, input int count, input bit gaps);
        int                  len;
        logic [ID_WIDTH-1:0] id;
        for (int k = 0; k < count; k++) begin
            len = pkt_len_q[p].pop_front();
            id  = ID_WIDTH'(8 * p + $urandom_range(7)); // Source 1 takes the upper half
            for (int b = 0; b < len; b++) begin
                if (gaps && $urandom_range(3) == 0) begin
                    tvalid[p] <= 1'b0;
                    repeat ($urandom_range(1, 3)) @(posedge aclk);
                end
                tvalid[p] <= 1'b1;
                tdata[p]  <= $urandom;
                tid[p]    <= id;
                tlast[p]  <= (b == len - 1);
                tkeep[p]  <= (b == len - 1) ? DATA_BYTES'($urandom | 1) : '1; // Byte 0 always set
                tstrb[p]  <= (b == len - 1) ? DATA_BYTES'($urandom | 1) : '1;
                do @(posedge aclk); while (!tready[p]);
            end
        end
        tvalid[p] <= 1'b0;
    endtask

    task automatic run_test(input string name, input int pct, input bit gaps);
        int err_start;
        err_start = errors;
        ready_pct <= pct;
        fork
            send_packets(0, PACKETS, gaps);
            send_packets(1, PACKETS, gaps);
        join
        @(posedge aclk);
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(posedge aclk);
        tests_done++;
        $display("Test %0d (%s) done with %0d errors", tests_done, name, errors - err_start);
    endtask

    initial begin
        int len;
        int total;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'h6d45_299a));
        areset_n  = 1'b0;
        out_ready = 1'b0;
        tvalid    = '0;
        tlast     = '0;
        for (int p = 0; p < 2; p++) begin
            tdata[p] = '0;
            tkeep[p] = '0;
            tstrb[p] = '0;
            tid[p]   = '0;
        end
        total = 0;
        for (int n = 0; n < NUM_TESTS * PACKETS; n++) begin
            for (int p = 0; p < 2; p++) begin
                len = $urandom_range(1, 6);
                pkt_len_q[p].push_back(len);
                total += len;
            end
        end
        total_beats = total; // Starts the watchdog
        repeat (RESET_CYCLES) @(posedge aclk);
        areset_n <= 1'b1;
        run_test("random traffic with gaps", 75, 1'b1);
        run_test("saturated sources", 100, 1'b0);
        run_test("heavy back-pressure", 40, 1'b1);
        $display("Tests %0d, beats checked %0d, errors %0d", tests_done, checked, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Checks failed");
        end
    end

    initial begin
        wait (total_beats != 0);
        #(PERIOD * 8 * total_beats + PERIOD * RESET_CYCLES);
        $display("Watchdog expired at %0t before all packets were delivered", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped by the watchdog");
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/st_bus_pkg.sv
rtl/st_arb_pkg.sv
rtl/axi4_stream_if.sv
rtl/avalon_st_if.sv
rtl/axi4s_to_avalon_st.sv
rtl/st_packet_arbiter.sv
rtl/st_merge_top.sv
test/tb_st_merge_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_st_merge_top -o sim_st_merge
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_st_merge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
